// File: Bender.yml
package:
  name: mipsCpuHarvard

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mipsPkg.sv
      - hdl/controlUnit.sv
      - hdl/registerFile.sv
      - hdl/alu.sv
      - hdl/nextPcLogic.sv
      - hdl/mipsCpuHarvard.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/mipsCpuHarvardTb.sv

// File: hdl/alu.sv
/*
  Arithmetic and logic unit
  Add, subtract, logic ops, signed compare, shifts and
  load-upper, with a zero flag for the branch compare
*/
`timescale 1ns/1ps
`default_nettype none

module alu
  import mipsPkg::*;
(
  input  wire aluOp_t     aluOp,
  input  wire word_t      operandA,
  input  wire word_t      operandB,
  input  wire logic [4:0] shamt,
  output word_t           result,
  output logic            zero
);

  always_comb
  begin
    case (aluOp)
      // Unsigned wraparound, no overflow trap
      aluAdd: result = operandA + operandB;
      aluSub: result = operandA - operandB;

      aluAnd: result = operandA & operandB;
      aluOr:  result = operandA | operandB;
      aluXor: result = operandA ^ operandB;

      // Signed compare, 0 or 1
      aluSlt:
      begin
        if ($signed(operandA) < $signed(operandB))
        begin
          result = word_t'(1);
        end
        else
        begin
          result = '0;
        end
      end

      // Shifts act on rt, amount from the instruction
      aluSll: result = operandB << shamt;
      aluSrl: result = operandB >> shamt;

      // Immediate goes to the upper half
      aluLui: result = {operandB[15:0], 16'h0000};

      default: result = '0;
    endcase
  end

  // BEQ and BNE look at this after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/controlUnit.sv
/*
  Instruction decoder
  Maps opcode and funct onto one control word.
  Encodings outside the subset decode to a NOP.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mipsParams.svh"

module controlUnit
  import mipsPkg::*;
(
  input  wire logic [5:0] opcode,
  input  wire logic [5:0] funct,
  output ctrl_t           ctrl
);

  always_comb
  begin
    // Default is a NOP
    // No write, no memory access, no transfer
    ctrl       = '0;
    ctrl.aluOp = aluAdd;

    case (opcode)
      `MIPS_OP_RTYPE:
      begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          `MIPS_FN_ADDU: ctrl.aluOp = aluAdd;
          `MIPS_FN_SUBU: ctrl.aluOp = aluSub;
          `MIPS_FN_AND:  ctrl.aluOp = aluAnd;
          `MIPS_FN_OR:   ctrl.aluOp = aluOr;
          `MIPS_FN_XOR:  ctrl.aluOp = aluXor;
          `MIPS_FN_SLT:  ctrl.aluOp = aluSlt;
          `MIPS_FN_SLL:  ctrl.aluOp = aluSll;
          `MIPS_FN_SRL:  ctrl.aluOp = aluSrl;
          `MIPS_FN_JR:
          begin
            // Target comes from rs, nothing written back
            ctrl.regWrite = 1'b0;
            ctrl.jumpReg  = 1'b1;
          end
          default:       ctrl.regWrite = 1'b0;
        endcase
      end

      `MIPS_OP_ADDIU:
      begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = aluAdd;
      end

      `MIPS_OP_ANDI:
      begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrcImm  = 1'b1;
        ctrl.zeroExtend = 1'b1;
        ctrl.aluOp      = aluAnd;
      end

      `MIPS_OP_ORI:
      begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrcImm  = 1'b1;
        ctrl.zeroExtend = 1'b1;
        ctrl.aluOp      = aluOr;
      end

      `MIPS_OP_LUI:
      begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrcImm  = 1'b1;
        ctrl.zeroExtend = 1'b1;
        ctrl.aluOp      = aluLui;
      end

      `MIPS_OP_LW:
      begin
        // Address is rs plus signed offset
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end

      `MIPS_OP_SW:
      begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end

      // Branches compare by subtraction
      `MIPS_OP_BEQ:
      begin
        ctrl.branchEq = 1'b1;
        ctrl.aluOp    = aluSub;
      end

      `MIPS_OP_BNE:
      begin
        ctrl.branchNe = 1'b1;
        ctrl.aluOp    = aluSub;
      end

      `MIPS_OP_J:    ctrl.jump = 1'b1;

      default:       ctrl.jump = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/mipsCpuHarvard.sv
/*
  Single-cycle MIPS core, Harvard memory interface
  Decodes the fetched word, runs the datapath and writes back
  in one enabled cycle. active drops once pc reaches zero.
*/
`timescale 1ns/1ps
`default_nettype none

module mipsCpuHarvard
  import mipsPkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  output logic       active,
  output word_t      registerV0,
  input  wire logic  clkEnable,
  // Instruction port, combinational read
  output word_t      instrAddress,
  input  wire word_t instrReaddata,
  // Data port, combinational read, write at the edge
  output word_t      dataAddress,
  output logic       dataWrite,
  output logic       dataRead,
  output word_t      dataWritedata,
  input  wire word_t dataReaddata
);

  // Instruction fields
  logic [5:0]  opcode;
  logic [5:0]  funct;
  logic [4:0]  shamt;
  logic [25:0] jumpField;
  regIdx_t     rs;
  regIdx_t     rt;
  regIdx_t     rd;
  imm16_t      imm;

  ctrl_t   ctrl;
  regIdx_t writeIdx;
  word_t   writeData;
  word_t   rsValue;
  word_t   rtValue;
  word_t   immExt;
  word_t   operandB;
  word_t   aluResult;
  logic    aluZero;

  assign opcode    = instrReaddata[31:26];
  assign rs        = instrReaddata[25:21];
  assign rt        = instrReaddata[20:16];
  assign rd        = instrReaddata[15:11];
  assign shamt     = instrReaddata[10:6];
  assign funct     = instrReaddata[5:0];
  assign imm       = instrReaddata[15:0];
  assign jumpField = instrReaddata[25:0];

  controlUnit i_controlUnit (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  // R-type writes rd, I-type writes rt
  assign writeIdx = ctrl.regDst ? rd : rt;

  // Logical immediates zero-extend, the rest sign-extend
  assign immExt   = ctrl.zeroExtend ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign operandB = ctrl.aluSrcImm ? immExt : rtValue;

  // Load data or ALU result back to the register file
  assign writeData = ctrl.memToReg ? dataReaddata : aluResult;

  registerFile i_registerFile (
    .clk         (clk),
    .reset       (reset),
    .writeEnable (ctrl.regWrite && clkEnable),
    .readIdxA    (rs),
    .readIdxB    (rt),
    .writeIdx    (writeIdx),
    .writeData   (writeData),
    .readDataA   (rsValue),
    .readDataB   (rtValue),
    .registerV0  (registerV0)
  );

  alu i_alu (
    .aluOp    (ctrl.aluOp),
    .operandA (rsValue),
    .operandB (operandB),
    .shamt    (shamt),
    .result   (aluResult),
    .zero     (aluZero)
  );

  nextPcLogic i_nextPcLogic (
    .clk        (clk),
    .reset      (reset),
    .clkEnable  (clkEnable),
    .ctrl       (ctrl),
    .aluZero    (aluZero),
    .rsValue    (rsValue),
    .immediate  (imm),
    .jumpTarget (jumpField),
    .pc         (instrAddress)
  );

  // Memory side, write is qualified by clkEnable in the memory
  assign dataAddress   = aluResult;
  assign dataWritedata = rtValue;
  assign dataRead      = ctrl.memRead;
  assign dataWrite     = ctrl.memWrite;

  // Halt flag, set by reset, cleared by a fetch from zero
  always_ff @(posedge clk)
  begin
    if (reset)
      active <= 1'b1;
    else if (clkEnable && (instrAddress == '0))
      active <= 1'b0;
  end

  // Decoder never issues a load and a store together
  a_noReadWrite : assert property (@(posedge clk) disable iff (reset)
    !(dataRead && dataWrite));

endmodule

`default_nettype wire

// File: hdl/mipsParams.svh
/*
  MIPS core constants
  Data width, register count, reset vector and the instruction
  encodings of the supported subset
*/
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath and register file sizing
`define MIPS_XLEN         32
`define MIPS_NUM_REGS     32
`define MIPS_RESET_VECTOR 32'hBFC00000
// v0 is exported for observation
`define MIPS_REG_V0       5'd2

// Opcode field, bits 31:26
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_J     6'h02
`define MIPS_OP_BEQ   6'h04
`define MIPS_OP_BNE   6'h05
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_ANDI  6'h0C
`define MIPS_OP_ORI   6'h0D
`define MIPS_OP_LUI   6'h0F
`define MIPS_OP_LW    6'h23
`define MIPS_OP_SW    6'h2B

// Funct field for R-type, bits 5:0
`define MIPS_FN_SLL  6'h00
`define MIPS_FN_SRL  6'h02
`define MIPS_FN_JR   6'h08
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND  6'h24
`define MIPS_FN_OR   6'h25
`define MIPS_FN_XOR  6'h26
`define MIPS_FN_SLT  6'h2A

`endif

// File: hdl/mipsPkg.sv
/*
  MIPS core types
  Word, register index and immediate types, the ALU operation
  select and the decoded control word
*/
`default_nettype none

`include "mipsParams.svh"

package mipsPkg;

  // One data or address word
  typedef logic [`MIPS_XLEN-1:0] word_t;

  // Register number, rs/rt/rd fields
  typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] regIdx_t;

  // Raw 16-bit immediate from the I-type format
  typedef logic [15:0] imm16_t;

  // ALU operation select
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSll,
    aluSrl,
    aluLui
  } aluOp_t;

  // Decoded control word, one per instruction
  typedef struct packed {
    logic   regWrite;
    logic   regDst;      // 1 selects rd, 0 selects rt
    logic   memToReg;    // Write back load data
    logic   memRead;
    logic   memWrite;
    logic   aluSrcImm;   // Operand B from immediate
    logic   zeroExtend;  // Logical immediates
    logic   branchEq;
    logic   branchNe;
    logic   jump;
    logic   jumpReg;
    aluOp_t aluOp;
  } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/nextPcLogic.sv
/*
  Program counter
  Holds pc and picks the next fetch address from PC+4,
  branch target, jump target or a register value
*/
`timescale 1ns/1ps
`default_nettype none

`include "mipsParams.svh"

module nextPcLogic
  import mipsPkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        clkEnable,
  input  wire ctrl_t       ctrl,
  input  wire logic        aluZero,
  input  wire word_t       rsValue,
  input  wire imm16_t      immediate,
  input  wire logic [25:0] jumpTarget,
  output word_t            pc
);

  word_t pcPlus4;
  word_t branchAddr;
  word_t jumpAddr;
  word_t pcNext;
  logic  branchTaken;

  // No delay slot, all targets relative to PC+4
  assign pcPlus4    = pc + word_t'(4);
  // Sign-extended word offset
  assign branchAddr = pcPlus4 + {{14{immediate[15]}}, immediate, 2'b00};
  // Stays inside the current 256 MB region
  assign jumpAddr   = {pcPlus4[31:28], jumpTarget, 2'b00};

  assign branchTaken = (ctrl.branchEq && aluZero) || (ctrl.branchNe && !aluZero);

  // JR first, then J, then branch
  always_comb
  begin
    if (ctrl.jumpReg)
      pcNext = rsValue;
    else if (ctrl.jump)
      pcNext = jumpAddr;
    else if (branchTaken)
      pcNext = branchAddr;
    else
      pcNext = pcPlus4;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= `MIPS_RESET_VECTOR;
    else if (clkEnable)
      pc <= pcNext;
  end

  // Every target formed above keeps the low bits clear
  a_pcAligned : assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
/*
  General purpose register file
  32 words, two combinational read ports, one write port,
  register 0 hard-wired to zero, v0 exported
*/
`timescale 1ns/1ps
`default_nettype none

`include "mipsParams.svh"

module registerFile
  import mipsPkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire logic    writeEnable,
  input  wire regIdx_t readIdxA,
  input  wire regIdx_t readIdxB,
  input  wire regIdx_t writeIdx,
  input  wire word_t   writeData,
  output word_t        readDataA,
  output word_t        readDataB,
  output word_t        registerV0
);

  word_t regs [`MIPS_NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    // Writes to $zero are dropped here
    else if (writeEnable && (writeIdx != '0))
    begin
      regs[writeIdx] <= writeData;
    end
  end

  // Reads see the old value until the edge
  assign readDataA  = regs[readIdxA];
  assign readDataB  = regs[readIdxB];
  assign registerV0 = regs[`MIPS_REG_V0];

  // $zero never picks up a written value
  a_zeroReadA : assert property (@(posedge clk) disable iff (reset)
    (readIdxA == '0) |-> (readDataA == '0));
  a_zeroReadB : assert property (@(posedge clk) disable iff (reset)
    (readIdxB == '0) |-> (readDataB == '0));

endmodule

`default_nettype wire

// File: mipsCpuHarvard.f
+incdir+hdl
hdl/mipsPkg.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/nextPcLogic.sv
hdl/mipsCpuHarvard.sv
testbench/mipsCpuHarvardTb.sv

// File: testbench/mipsCpuHarvardTb.sv
/*
  Testbench for the single-cycle MIPS core
  Models instruction ROM and data RAM, loads programs from
  the input file, runs each to the JR to zero and checks v0,
  the halt flag and stored memory words
*/
`timescale 1ns/1ps
`default_nettype none

`include "mipsParams.svh"

module mipsCpuHarvardTb
  import mipsPkg::*;
;

  localparam int ROM_WORDS  = 64;
  localparam int RAM_WORDS  = 256;
  localparam int STIM_WORDS = 512;

  logic  clk = 1'b0;
  logic  reset = 1'b1;
  logic  clkEnable = 1'b0;
  word_t instrReaddata;
  word_t dataReaddata;
  logic  active;
  word_t registerV0;
  word_t instrAddress;
  word_t dataAddress;
  logic  dataWrite;
  logic  dataRead;
  word_t dataWritedata;

  word_t  rom [ROM_WORDS];
  word_t  ram [RAM_WORDS];
  word_t  stim [STIM_WORDS];
  word_t  romOffset;
  int     numRecords = 0;
  int     stimPtr;
  int     errCount = 0;
  int     passCount = 0;
  int     failCount = 0;
  integer seed;

  mipsCpuHarvard i_dut (
    .clk           (clk),
    .reset         (reset),
    .active        (active),
    .registerV0    (registerV0),
    .clkEnable     (clkEnable),
    .instrAddress  (instrAddress),
    .instrReaddata (instrReaddata),
    .dataAddress   (dataAddress),
    .dataWrite     (dataWrite),
    .dataRead      (dataRead),
    .dataWritedata (dataWritedata),
    .dataReaddata  (dataReaddata)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ROM sits at the reset vector
  // Address zero fetches a NOP
  always_comb
  begin
    romOffset = instrAddress - `MIPS_RESET_VECTOR;
    if (instrAddress == '0)
      instrReaddata = '0;
    else if (romOffset < word_t'(ROM_WORDS * 4))
      instrReaddata = rom[romOffset[7:2]];
    else
      instrReaddata = '0;
  end

  // Data RAM window covers the lowest 1 KB
  // Read data only shows while the DUT requests a read
  always_comb
  begin
    if (dataRead && (dataAddress < word_t'(RAM_WORDS * 4)))
      dataReaddata = ram[dataAddress[9:2]];
    else
      dataReaddata = '0;
  end

  // Stores only land on enabled edges
  always @(posedge clk)
  begin
    if (dataWrite && clkEnable && (dataAddress < word_t'(RAM_WORDS * 4)))
      ram[dataAddress[9:2]] <= dataWritedata;
  end

  task automatic checkWord(input string sigName, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0d ns: %s = %h, expected %h", $time, sigName, got, exp);
      errCount++;
    end
  endtask

  task automatic checkBit(input string sigName, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0d ns: %s = %b, expected %b", $time, sigName, got, exp);
      errCount++;
    end
  endtask

  // Pattern built from the full byte address
  task automatic fillRam();
    for (int i = 0; i < RAM_WORDS; i++)
    begin
      ram[i] = 32'hA5A50000 ^ word_t'(i << 2);
    end
  endtask

  task automatic runRecord(input int recNum);
    int    count;
    logic  randomEnable;
    word_t expV0;
    word_t ramAddr;
    word_t ramExp;
    int    errorsBefore;
    int    cycles;
    begin
      errorsBefore = errCount;
      cycles       = 0;
      count        = stim[stimPtr];
      if (count > ROM_WORDS)
      begin
        $display("Record %0d holds more instructions than the ROM can take", recNum);
        errCount++;
        count = ROM_WORDS;
      end
      for (int i = 0; i < ROM_WORDS; i++)
      begin
        rom[i] = (i < count) ? stim[stimPtr + 1 + i] : '0;
      end
      stimPtr      = stimPtr + 1 + count;
      randomEnable = stim[stimPtr][0];
      expV0        = stim[stimPtr + 1];
      ramAddr      = stim[stimPtr + 2];
      ramExp       = stim[stimPtr + 3];
      stimPtr      = stimPtr + 4;
      fillRam();

      // Three rising edges in reset
      @(negedge clk);
      reset     = 1'b1;
      clkEnable = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      checkBit("active", active, 1'b1);
      checkWord("registerV0", registerV0, '0);

      // Run until the fetch from zero clears active
      while (active === 1'b1)
      begin
        clkEnable = randomEnable ? (($random(seed) & 3) != 0) : 1'b1;
        @(negedge clk);
        cycles++;
      end
      clkEnable = 1'b0;

      checkBit("active", active, 1'b0);
      checkWord("registerV0", registerV0, expV0);
      // The NOP at zero retired once
      checkWord("instrAddress", instrAddress, word_t'(4));
      if (ramAddr != 32'hFFFFFFFF)
      begin
        if (ramAddr < word_t'(RAM_WORDS * 4))
          checkWord("ram", ram[ramAddr[9:2]], ramExp);
        else
        begin
          $display("Record %0d asks for a RAM word outside the modelled window", recNum);
          errCount++;
        end
      end

      if (errCount == errorsBefore)
        passCount++;
      else
        failCount++;
      $display("Test %0d (%s enable): %s after %0d cycles, v0 = %h", recNum,
               randomEnable ? "random" : "steady",
               (errCount == errorsBefore) ? "ok" : "error", cycles, registerV0);
    end
  endtask

  initial
  begin
    seed = 48297;
    $readmemh("testbench/programInput.mem", stim);
    if ($isunknown(stim[0]) || (stim[0] == '0))
    begin
      $display("No test records could be read from the input file");
      errCount++;
    end
    else
    begin
      numRecords = stim[0];
      stimPtr    = 1;
      for (int r = 1; r <= numRecords; r++)
      begin
        runRecord(r);
      end
    end
    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (errCount == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // 64 instruction cycles per record with a 4x margin for stalls
  initial
  begin
    wait (numRecords > 0);
    #(numRecords * 64 * 4 * 4);
    $display("Timeout: a program never reached the jump to address zero");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/programInput.mem
// Word 0 is the record count. Each record then holds: instruction count,
// the instructions, enable mode (1 = random clkEnable), expected v0,
// RAM check byte address (FFFFFFFF = none) and the expected RAM word
00000005
// R-type arithmetic and logic, v0 = (t2 << 4) + (t3 >> 2) ^ and + or - xor + slt
00000010
34080F0F 340900FF 01095021 01095823
01096024 01096825 01097026 0128782A
000A8100 000B8882 02111021 004C1026
004D1021 004E1023 004F1021 00000008
00000000 0001047B FFFFFFFF 00000000
// Immediates, negative ADDIU, zero-extended ANDI/ORI, LUI, write to $zero
0000000A
2408FFFB 3109F0F0 340A8001 3C0B1234
24007777 01691021 004A1021 00481021
00401021 00000008
00000000 123570EC FFFFFFFF 00000000
// Store then load at 0x48
00000006
3C08CAFE 3508BABE 24090040 AD280008
8D220008 00000008
00000000 CAFEBABE 00000048 CAFEBABE
// Counting loop, taken and untaken BEQ/BNE, J over a wrong-path add
0000000F
24080003 24020000 24420005 2508FFFF
1500FFFD 11000001 24420064 10400004
14000003 24420020 0BF0000D 24420200
24020BAD 24420001 00000008
00000000 00000030 FFFFFFFF 00000000
// Same control flow program with random clkEnable
0000000F
24080003 24020000 24420005 2508FFFF
1500FFFD 11000001 24420064 10400004
14000003 24420020 0BF0000D 24420200
24020BAD 24420001 00000008
00000001 00000030 FFFFFFFF 00000000
